/* tb.f */
common/core_types_pkg.sv
rtl/alu.sv
alu_reg_pipeline/oc_queue.sv
alu_reg_pipeline/alu_reg_pipeline.sv
alu_reg_pipeline/alu_reg_pipeline_wrapper.sv
tests/alu_reg_pipeline_chk.sv
tests/alu_reg_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module alu_reg_pipeline_tb

sim_out=$(./obj_dir/Valu_reg_pipeline_tb 2>&1) || true
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
	exit 0
fi
exit 1

/* tests/alu_reg_pipeline_tb.sv */
// testbench for the ALU register pipe wrapper: random bursts, reference model and checks
module alu_reg_pipeline_tb import core_types_pkg::*; ();

	localparam int FF_PIPES = 4;
	localparam int BURSTS = 8;
	localparam int BURST_LEN = 25;
	localparam int SLOW_BURST = 5;
	localparam int STALL_CYCLES = 20;
	localparam int STALL_OPS = 3;
	// random ops plus the directed stall ops
	localparam int TOTAL_OPS = BURSTS * BURST_LEN + STALL_OPS;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 40 + 1000;
	// reg A, reg B, banks, then pipes
	localparam int LANES = 2 + PRF_BANK_COUNT + FF_PIPES;
	localparam int SRC_REG = 0;
	localparam int SRC_BUS = 1;
	localparam int SRC_FF = 2;
	localparam alu_op_t OP_CODES [10] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_OR, ALU_AND, ALU_SUB, ALU_SRA};

	logic CLK = 1'b0;
	logic nRST;
	logic next_issue_valid;
	issue_t next_issue;
	logic last_issue_ready;
	logic next_A_reg_read_resp_valid;
	word_t next_A_reg_read_resp_data;
	logic next_B_reg_read_resp_valid;
	word_t next_B_reg_read_resp_data;
	word_t [PRF_BANK_COUNT-1:0] next_bus_forward_data_by_bank;
	logic [FF_PIPES-1:0] next_fast_forward_data_valid_by_pipe;
	word_t [FF_PIPES-1:0] next_fast_forward_data_by_pipe;
	logic last_WB_valid;
	wb_t last_WB;
	logic next_WB_ready;
	logic last_pipe_fast_forward_notif_valid;
	pr_t last_pipe_fast_forward_notif_PR;
	logic last_pipe_fast_forward_data_valid;
	word_t last_pipe_fast_forward_data;

	logic [31:0] lfsr;
	word_t lane_val [LANES];
	wb_t exp_wb [TOTAL_OPS];
	int issued;
	int notif_ptr;
	int data_ptr;
	int wb_ptr;
	int mismatch_count;
	int fail_count;
	int gap;
	int cycle_count = 0;
	logic [1:0] rdy_hist;
	logic hold_operands;
	logic slow_wb;

	alu_reg_pipeline_wrapper #(
		.IS_OC_BUFFER_SIZE(2),
		.OC_ENTRIES(3),
		.FAST_FORWARD_PIPE_COUNT(FF_PIPES)
	) DUT (.*);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: ops still pending after %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	// ------------------------------
	// random source, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic out_bit;
		r = '0;
		for (int i = 0; i < n; i++) begin
			out_bit = lfsr[0];
			lfsr = lfsr >> 1;
			if (out_bit) begin
				lfsr = lfsr ^ 32'h8020_0003;
			end
			r = {r[30:0], out_bit};
		end
		return r;
	endfunction

	function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a + ~b + 32'd1;
			ALU_SLL: return a << sh;
			ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> sh;
			// fill vacated bits with the sign
			ALU_SRA: return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			default: return '0;
		endcase
	endfunction

	function automatic word_t src_value(input operand_src_t s, input logic is_b);
		if (s.is_reg) begin
			return is_b ? lane_val[1] : lane_val[0];
		end
		if (s.is_bus_forward) begin
			return lane_val[2 + int'(s.bank)];
		end
		return lane_val[2 + PRF_BANK_COUNT + int'(s.ff_pipe)];
	endfunction

	function automatic operand_src_t random_src();
		operand_src_t s;
		logic [1:0] kind;
		s = '0;
		kind = 2'(rand_bits(2));
		s.bank = bank_t'(rand_bits(LOG_PRF_BANK_COUNT));
		s.ff_pipe = ff_pipe_t'(rand_bits(2));
		case (kind)
			2'd0: s.is_reg = 1'b1;
			2'd1: s.is_bus_forward = 1'b1;
			default: s.is_fast_forward = 1'b1;
		endcase
		return s;
	endfunction

	// sel is the bank or the pipe number
	function automatic operand_src_t fixed_src(input int kind, input int sel);
		operand_src_t s;
		s = '0;
		case (kind)
			SRC_REG: begin
				s.is_reg = 1'b1;
			end
			SRC_BUS: begin
				s.is_bus_forward = 1'b1;
				s.bank = bank_t'(sel);
			end
			default: begin
				s.is_fast_forward = 1'b1;
				s.ff_pipe = ff_pipe_t'(sel);
			end
		endcase
		return s;
	endfunction

	function automatic issue_t random_op();
		issue_t op;
		op.op = OP_CODES[rand_bits(4) % 10];
		op.src_A = random_src();
		op.src_B = random_src();
		op.dest_PR = pr_t'(rand_bits(LOG_PR_COUNT));
		op.ROB_index = rob_t'(issued);
		return op;
	endfunction

	// ------------------------------
	task automatic check_reset_quiet();
		assert (!last_issue_ready && !last_WB_valid && !last_pipe_fast_forward_notif_valid
			&& !last_pipe_fast_forward_data_valid) else begin
			fail_count++;
			$display("A valid or issue ready output is high during reset");
		end
		assert (last_WB == '0 && last_pipe_fast_forward_notif_PR == '0
			&& last_pipe_fast_forward_data == '0) else begin
			fail_count++;
			$display("A data output is not zero during reset");
		end
	endtask

	task automatic check_outputs();
		if (last_pipe_fast_forward_notif_valid) begin
			assert (notif_ptr < issued) else begin
				fail_count++;
				$display("Notification pulse with no op left to announce");
			end
			if (notif_ptr < issued) begin
				assert (last_pipe_fast_forward_notif_PR == exp_wb[notif_ptr].PR) else begin
					mismatch_count++;
					$display("Mismatch notif_pr op %0d: expected %h, actual %h", notif_ptr,
						exp_wb[notif_ptr].PR, last_pipe_fast_forward_notif_PR);
				end
				notif_ptr++;
			end
		end
		if (last_pipe_fast_forward_data_valid) begin
			assert (data_ptr < issued) else begin
				fail_count++;
				$display("Forward data pulse with no op left to announce");
			end
			if (data_ptr < issued) begin
				assert (last_pipe_fast_forward_data == exp_wb[data_ptr].data) else begin
					mismatch_count++;
					$display("Mismatch ff_data op %0d: expected %h, actual %h", data_ptr,
						exp_wb[data_ptr].data, last_pipe_fast_forward_data);
				end
				data_ptr++;
			end
		end
		// completed write needs ready from two cycles back
		if (last_WB_valid && rdy_hist[1]) begin
			assert (wb_ptr < issued) else begin
				fail_count++;
				$display("Writeback completed with no op outstanding");
			end
			if (wb_ptr < issued) begin
				assert (last_WB == exp_wb[wb_ptr]) else begin
					mismatch_count++;
					$display("Mismatch writeback op %0d: expected %h, actual %h", wb_ptr,
						exp_wb[wb_ptr], last_WB);
				end
				wb_ptr++;
			end
		end
	endtask

	task automatic drive_toggles();
		if (hold_operands) begin
			next_A_reg_read_resp_valid = 1'b0;
			next_B_reg_read_resp_valid = 1'b0;
			next_fast_forward_data_valid_by_pipe = '0;
		end else begin
			next_A_reg_read_resp_valid = 1'(rand_bits(1));
			next_B_reg_read_resp_valid = 1'(rand_bits(1));
			next_fast_forward_data_valid_by_pipe = FF_PIPES'(rand_bits(FF_PIPES));
		end
		if (slow_wb) begin
			next_WB_ready = (rand_bits(3) == 32'd0);
		end else begin
			next_WB_ready = 1'(rand_bits(1));
		end
		rdy_hist = {rdy_hist[0], next_WB_ready};
	endtask

	task automatic step();
		@(negedge CLK);
		check_outputs();
		drive_toggles();
		next_issue_valid = 1'b0;
	endtask

	task automatic send_op(input issue_t op);
		wb_t e;
		e.data = model_alu(op.op, src_value(op.src_A, 1'b0), src_value(op.src_B, 1'b1));
		e.PR = op.dest_PR;
		e.ROB_index = op.ROB_index;
		exp_wb[issued] = e;
		issued++;
		next_issue = op;
		next_issue_valid = 1'b1;
	endtask

	task automatic load_burst_values();
		word_t v;
		for (int i = 0; i < LANES; i++) begin
			v = rand_bits(32);
			// lane number in the middle keeps lanes distinct
			v[8:5] = 4'(i);
			lane_val[i] = v;
		end
		next_A_reg_read_resp_data = lane_val[0];
		next_B_reg_read_resp_data = lane_val[1];
		for (int b = 0; b < PRF_BANK_COUNT; b++) begin
			next_bus_forward_data_by_bank[b] = lane_val[2 + b];
		end
		for (int p = 0; p < FF_PIPES; p++) begin
			next_fast_forward_data_by_pipe[p] = lane_val[2 + PRF_BANK_COUNT + p];
		end
	endtask

	task automatic run_burst();
		int sent;
		sent = 0;
		while (sent < BURST_LEN) begin
			step();
			if (gap > 0) begin
				gap--;
			end else if (last_issue_ready) begin
				send_op(random_op());
				sent++;
				gap = int'(rand_bits(2));
			end
		end
	endtask

	task automatic drain();
		while (wb_ptr < issued) begin
			step();
		end
	endtask

	// operand valids held low for a while, only one operand waits on a valid
	task automatic stall_test(input operand_src_t src_a, input operand_src_t src_b);
		issue_t op;
		int done_before;
		op = random_op();
		op.src_A = src_a;
		op.src_B = src_b;
		hold_operands = 1'b1;
		step();
		while (!last_issue_ready) begin
			step();
		end
		send_op(op);
		done_before = wb_ptr;
		repeat (STALL_CYCLES) begin
			step();
			assert (wb_ptr == done_before) else begin
				fail_count++;
				$display("Stalled op wrote back while its operand valids were held low");
			end
		end
		hold_operands = 1'b0;
		drain();
	endtask

	// ------------------------------
	initial begin
		nRST = 1'b0;
		next_issue_valid = 1'b0;
		next_issue = '0;
		next_A_reg_read_resp_valid = 1'b0;
		next_A_reg_read_resp_data = '0;
		next_B_reg_read_resp_valid = 1'b0;
		next_B_reg_read_resp_data = '0;
		next_bus_forward_data_by_bank = '0;
		next_fast_forward_data_valid_by_pipe = '0;
		next_fast_forward_data_by_pipe = '0;
		next_WB_ready = 1'b0;
		lfsr = 32'd96383;
		issued = 0;
		notif_ptr = 0;
		data_ptr = 0;
		wb_ptr = 0;
		mismatch_count = 0;
		fail_count = 0;
		gap = 0;
		rdy_hist = '0;
		hold_operands = 1'b0;
		slow_wb = 1'b0;
		repeat (5) begin
			@(negedge CLK);
			check_reset_quiet();
		end
		nRST = 1'b1;
		for (int b = 0; b < BURSTS; b++) begin
			slow_wb = (b == SLOW_BURST);
			load_burst_values();
			run_burst();
			drain();
		end
		slow_wb = 1'b0;
		// reg A, reg B, then pipe 1 as the waiting operand
		stall_test(fixed_src(SRC_REG, 0), fixed_src(SRC_BUS, 3));
		stall_test(fixed_src(SRC_BUS, 2), fixed_src(SRC_REG, 0));
		stall_test(fixed_src(SRC_BUS, 0), fixed_src(SRC_FF, 1));
		// catch stray pulses
		repeat (10) begin
			step();
		end
		assert (notif_ptr == issued && data_ptr == issued && wb_ptr == issued) else begin
			fail_count++;
			$display("Pulse or writeback count differs from the %0d issued ops", issued);
		end
		$display("Error counts: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count + fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* tests/alu_reg_pipeline_chk.sv */
// concurrent checks on the ALU register pipe, bound into alu_reg_pipeline
module alu_reg_pipeline_chk import core_types_pkg::*; #(
	parameter int OC_ENTRIES = 3
) (
	input logic CLK,
	input logic nRST,
	input logic issue_valid,
	input issue_t issue,
	input logic [$clog2(OC_ENTRIES+1)-1:0] free_count,
	input logic WB_valid,
	input wb_t WB,
	input logic WB_ready,
	input logic pipe_fast_forward_notif_valid,
	input logic pipe_fast_forward_data_valid
);

	// ------------------------------
	// issue side
	assert property (@(posedge CLK) disable iff (!nRST)
		issue_valid |-> free_count != '0)
		else $error("issue arrived while the operand queue was full");

	assert property (@(posedge CLK) disable iff (!nRST)
		issue_valid |->
			$onehot({issue.src_A.is_reg, issue.src_A.is_bus_forward, issue.src_A.is_fast_forward})
			&& $onehot({issue.src_B.is_reg, issue.src_B.is_bus_forward,
				issue.src_B.is_fast_forward}))
		else $error("operand source does not have exactly one flag set");

	// ------------------------------
	// writeback side
	assert property (@(posedge CLK) disable iff (!nRST)
		WB_valid && !WB_ready |=> WB_valid && $stable(WB))
		else $error("writeback register changed while stalled");

	// reset has had one edge to settle
	assert property (@(posedge CLK)
		(!nRST && $past(!nRST)) |-> !(issue_valid || WB_valid
			|| pipe_fast_forward_notif_valid || pipe_fast_forward_data_valid))
		else $error("valid signal high during reset");

endmodule

bind alu_reg_pipeline alu_reg_pipeline_chk #(
	.OC_ENTRIES(OC_ENTRIES)
) chk_inst (
	.CLK(CLK),
	.nRST(nRST),
	.issue_valid(issue_valid),
	.issue(issue),
	.free_count(free_count),
	.WB_valid(WB_valid),
	.WB(WB),
	.WB_ready(WB_ready),
	.pipe_fast_forward_notif_valid(pipe_fast_forward_notif_valid),
	.pipe_fast_forward_data_valid(pipe_fast_forward_data_valid)
);

/* alu_reg_pipeline/alu_reg_pipeline_wrapper.sv */
// top level that registers every input and output of the ALU register pipe once
module alu_reg_pipeline_wrapper import core_types_pkg::*; #(
	parameter int IS_OC_BUFFER_SIZE = 2,
	parameter int OC_ENTRIES = IS_OC_BUFFER_SIZE + 1,
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input logic CLK,
	input logic nRST,

	input logic next_issue_valid,
	input issue_t next_issue,
	output logic last_issue_ready,

	input logic next_A_reg_read_resp_valid,
	input word_t next_A_reg_read_resp_data,
	input logic next_B_reg_read_resp_valid,
	input word_t next_B_reg_read_resp_data,
	input word_t [PRF_BANK_COUNT-1:0] next_bus_forward_data_by_bank,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] next_fast_forward_data_valid_by_pipe,
	input word_t [FAST_FORWARD_PIPE_COUNT-1:0] next_fast_forward_data_by_pipe,

	output logic last_WB_valid,
	output wb_t last_WB,
	input logic next_WB_ready,

	output logic last_pipe_fast_forward_notif_valid,
	output pr_t last_pipe_fast_forward_notif_PR,
	output logic last_pipe_fast_forward_data_valid,
	output word_t last_pipe_fast_forward_data
);

	// ------------------------------
	// pipe side signals
	logic issue_valid;
	issue_t issue;
	logic issue_ready;
	logic A_reg_read_resp_valid;
	word_t A_reg_read_resp_data;
	logic B_reg_read_resp_valid;
	word_t B_reg_read_resp_data;
	word_t [PRF_BANK_COUNT-1:0] bus_forward_data_by_bank;
	logic [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_valid_by_pipe;
	word_t [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_by_pipe;
	logic WB_valid;
	wb_t WB;
	logic WB_ready;
	logic pipe_fast_forward_notif_valid;
	pr_t pipe_fast_forward_notif_PR;
	logic pipe_fast_forward_data_valid;
	word_t pipe_fast_forward_data;

	alu_reg_pipeline #(
		.IS_OC_BUFFER_SIZE(IS_OC_BUFFER_SIZE),
		.OC_ENTRIES(OC_ENTRIES),
		.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
	) WRAPPED_MODULE (.*);

	// ------------------------------
	// one register stage each way
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			// inputs
			issue_valid <= 1'b0;
			issue <= '0;
			A_reg_read_resp_valid <= 1'b0;
			A_reg_read_resp_data <= '0;
			B_reg_read_resp_valid <= 1'b0;
			B_reg_read_resp_data <= '0;
			bus_forward_data_by_bank <= '0;
			fast_forward_data_valid_by_pipe <= '0;
			fast_forward_data_by_pipe <= '0;
			WB_ready <= 1'b0;
			// outputs
			last_issue_ready <= 1'b0;
			last_WB_valid <= 1'b0;
			last_WB <= '0;
			last_pipe_fast_forward_notif_valid <= 1'b0;
			last_pipe_fast_forward_notif_PR <= '0;
			last_pipe_fast_forward_data_valid <= 1'b0;
			last_pipe_fast_forward_data <= '0;
		end else begin
			issue_valid <= next_issue_valid;
			issue <= next_issue;
			A_reg_read_resp_valid <= next_A_reg_read_resp_valid;
			A_reg_read_resp_data <= next_A_reg_read_resp_data;
			B_reg_read_resp_valid <= next_B_reg_read_resp_valid;
			B_reg_read_resp_data <= next_B_reg_read_resp_data;
			bus_forward_data_by_bank <= next_bus_forward_data_by_bank;
			fast_forward_data_valid_by_pipe <= next_fast_forward_data_valid_by_pipe;
			fast_forward_data_by_pipe <= next_fast_forward_data_by_pipe;
			WB_ready <= next_WB_ready;
			last_issue_ready <= issue_ready;
			last_WB_valid <= WB_valid;
			last_WB <= WB;
			last_pipe_fast_forward_notif_valid <= pipe_fast_forward_notif_valid;
			last_pipe_fast_forward_notif_PR <= pipe_fast_forward_notif_PR;
			last_pipe_fast_forward_data_valid <= pipe_fast_forward_data_valid;
			last_pipe_fast_forward_data <= pipe_fast_forward_data;
		end
	end

endmodule

/* alu_reg_pipeline/alu_reg_pipeline.sv */
// ALU register pipe: issue ready, operand queue, ALU, writeback register and fast-forward outputs
module alu_reg_pipeline import core_types_pkg::*; #(
	parameter int IS_OC_BUFFER_SIZE = 2,
	parameter int OC_ENTRIES = IS_OC_BUFFER_SIZE + 1,
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input logic CLK,
	input logic nRST,

	// issue from IQ
	input logic issue_valid,
	input issue_t issue,
	output logic issue_ready,

	// register file responses and forwarding
	input logic A_reg_read_resp_valid,
	input word_t A_reg_read_resp_data,
	input logic B_reg_read_resp_valid,
	input word_t B_reg_read_resp_data,
	input word_t [PRF_BANK_COUNT-1:0] bus_forward_data_by_bank,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_valid_by_pipe,
	input word_t [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_by_pipe,

	// writeback to register file
	output logic WB_valid,
	output wb_t WB,
	input logic WB_ready,

	// this pipe's own forward
	output logic pipe_fast_forward_notif_valid,
	output pr_t pipe_fast_forward_notif_PR,
	output logic pipe_fast_forward_data_valid,
	output word_t pipe_fast_forward_data
);

	localparam int CNT_W = $clog2(OC_ENTRIES + 1);

	logic [CNT_W-1:0] free_count;
	logic deq;
	logic head_ready;
	alu_op_t head_op;
	word_t head_A;
	word_t head_B;
	pr_t head_PR;
	rob_t head_ROB_index;
	word_t alu_result;
	// result just landed in WB
	logic wb_fresh;

	// ------------------------------
	// issue side
	// keep a skid margin for ops already in flight
	assign issue_ready = (int'(free_count) - int'(issue_valid)) > IS_OC_BUFFER_SIZE;

	oc_queue #(
		.OC_ENTRIES(OC_ENTRIES),
		.FAST_FORWARD_PIPE_COUNT(FAST_FORWARD_PIPE_COUNT)
	) oc_queue_inst (
		.CLK(CLK),
		.nRST(nRST),
		.enq_valid(issue_valid),
		.enq(issue),
		.bus_forward_data_by_bank(bus_forward_data_by_bank),
		.A_reg_read_resp_valid(A_reg_read_resp_valid),
		.A_reg_read_resp_data(A_reg_read_resp_data),
		.B_reg_read_resp_valid(B_reg_read_resp_valid),
		.B_reg_read_resp_data(B_reg_read_resp_data),
		.fast_forward_data_valid_by_pipe(fast_forward_data_valid_by_pipe),
		.fast_forward_data_by_pipe(fast_forward_data_by_pipe),
		.deq(deq),
		.head_ready(head_ready),
		.head_op(head_op),
		.head_A(head_A),
		.head_B(head_B),
		.head_PR(head_PR),
		.head_ROB_index(head_ROB_index),
		.free_count(free_count)
	);

	alu alu_inst (
		.op(head_op),
		.A(head_A),
		.B(head_B),
		.result(alu_result)
	);

	// ------------------------------
	// writeback register
	// head moves when WB is empty or completing this cycle
	assign deq = head_ready && (!WB_valid || WB_ready);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			WB_valid <= 1'b0;
			WB <= '0;
			wb_fresh <= 1'b0;
		end else begin
			wb_fresh <= deq;
			if (deq) begin
				WB_valid <= 1'b1;
				WB.data <= alu_result;
				WB.PR <= head_PR;
				WB.ROB_index <= head_ROB_index;
			end else if (WB_ready) begin
				WB_valid <= 1'b0;
			end
		end
	end

	// notif with the head pop, data one cycle later
	assign pipe_fast_forward_notif_valid = deq;
	assign pipe_fast_forward_notif_PR = deq ? head_PR : '0;
	assign pipe_fast_forward_data_valid = wb_fresh;
	assign pipe_fast_forward_data = wb_fresh ? WB.data : '0;

endmodule

/* alu_reg_pipeline/oc_queue.sv */
// operand-collection queue with reg-response, bus-forward and fast-forward operand capture
module oc_queue import core_types_pkg::*; #(
	parameter int OC_ENTRIES = 3,
	parameter int FAST_FORWARD_PIPE_COUNT = 4
) (
	input logic CLK,
	input logic nRST,
	input logic enq_valid,
	input issue_t enq,
	input word_t [PRF_BANK_COUNT-1:0] bus_forward_data_by_bank,
	input logic A_reg_read_resp_valid,
	input word_t A_reg_read_resp_data,
	input logic B_reg_read_resp_valid,
	input word_t B_reg_read_resp_data,
	input logic [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_valid_by_pipe,
	input word_t [FAST_FORWARD_PIPE_COUNT-1:0] fast_forward_data_by_pipe,
	input logic deq,
	output logic head_ready,
	output alu_op_t head_op,
	output word_t head_A,
	output word_t head_B,
	output pr_t head_PR,
	output rob_t head_ROB_index,
	output logic [$clog2(OC_ENTRIES+1)-1:0] free_count
);

	localparam int IDX_W = (OC_ENTRIES > 1) ? $clog2(OC_ENTRIES) : 1;
	localparam int CNT_W = $clog2(OC_ENTRIES + 1);

	// ------------------------------
	// entry storage, operand 0 is A and 1 is B
	alu_op_t op_q [OC_ENTRIES];
	pr_t pr_q [OC_ENTRIES];
	rob_t rob_q [OC_ENTRIES];
	operand_src_t [1:0] src_q [OC_ENTRIES];
	word_t [1:0] data_q [OC_ENTRIES];
	logic [1:0] have_q [OC_ENTRIES];

	logic [IDX_W-1:0] head;
	logic [IDX_W-1:0] tail;
	logic [CNT_W-1:0] count;

	// lanes padded out to the full pipe index range
	logic [MAX_FF_PIPES-1:0] ff_valid;
	word_t [MAX_FF_PIPES-1:0] ff_data;

	logic [1:0] resp_valid;
	word_t [1:0] resp_data;
	operand_src_t [1:0] enq_src;

	logic [1:0] enq_have;
	word_t [1:0] enq_data;
	logic [1:0] take [OC_ENTRIES];
	word_t [1:0] take_data [OC_ENTRIES];

	function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
		if (int'(idx) == OC_ENTRIES - 1) begin
			return '0;
		end
		return idx + IDX_W'(1);
	endfunction

	assign resp_valid = {B_reg_read_resp_valid, A_reg_read_resp_valid};
	assign resp_data = {B_reg_read_resp_data, A_reg_read_resp_data};
	assign enq_src = {enq.src_B, enq.src_A};

	always_comb begin
		ff_valid = '0;
		ff_data = '0;
		for (int p = 0; p < FAST_FORWARD_PIPE_COUNT; p++) begin
			ff_valid[p] = fast_forward_data_valid_by_pipe[p];
			ff_data[p] = fast_forward_data_by_pipe[p];
		end
	end

	// ------------------------------
	// operands available to the entering op
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			enq_have[k] = 1'b0;
			enq_data[k] = '0;
			if (enq_src[k].is_bus_forward) begin
				enq_have[k] = 1'b1;
				enq_data[k] = bus_forward_data_by_bank[enq_src[k].bank];
			end else if (enq_src[k].is_fast_forward && ff_valid[enq_src[k].ff_pipe]) begin
				enq_have[k] = 1'b1;
				enq_data[k] = ff_data[enq_src[k].ff_pipe];
			end
		end
	end

	// walk from head so a reg response lands on the oldest waiter
	always_comb begin
		logic [1:0] claimed;
		int idx;
		claimed = '0;
		idx = 0;
		for (int e = 0; e < OC_ENTRIES; e++) begin
			take[e] = '0;
			take_data[e] = '0;
		end
		for (int i = 0; i < OC_ENTRIES; i++) begin
			idx = int'(head) + i;
			if (idx >= OC_ENTRIES) begin
				idx = idx - OC_ENTRIES;
			end
			if (i < int'(count)) begin
				for (int k = 0; k < 2; k++) begin
					if (!have_q[idx][k]) begin
						if (src_q[idx][k].is_reg && resp_valid[k] && !claimed[k]) begin
							take[idx][k] = 1'b1;
							take_data[idx][k] = resp_data[k];
							claimed[k] = 1'b1;
						end else if (src_q[idx][k].is_fast_forward &&
							ff_valid[src_q[idx][k].ff_pipe]) begin
							take[idx][k] = 1'b1;
							take_data[idx][k] = ff_data[src_q[idx][k].ff_pipe];
						end
					end
				end
			end
		end
	end

	// ------------------------------
	// pointers and collected flags
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int e = 0; e < OC_ENTRIES; e++) begin
				have_q[e] <= '0;
			end
		end else begin
			if (enq_valid) begin
				tail <= next_idx(tail);
			end
			if (deq) begin
				head <= next_idx(head);
			end
			count <= count + CNT_W'(enq_valid) - CNT_W'(deq);
			for (int e = 0; e < OC_ENTRIES; e++) begin
				have_q[e] <= have_q[e] | take[e];
			end
			if (enq_valid) begin
				have_q[tail] <= enq_have;
			end
		end
	end

	always_ff @(posedge CLK) begin
		for (int e = 0; e < OC_ENTRIES; e++) begin
			for (int k = 0; k < 2; k++) begin
				if (take[e][k]) begin
					data_q[e][k] <= take_data[e][k];
				end
			end
		end
		if (enq_valid) begin
			op_q[tail] <= enq.op;
			pr_q[tail] <= enq.dest_PR;
			rob_q[tail] <= enq.ROB_index;
			src_q[tail] <= enq_src;
			data_q[tail] <= enq_data;
		end
	end

	assign head_ready = (count != '0) && (have_q[head] == 2'b11);
	assign head_op = op_q[head];
	assign head_A = data_q[head][0];
	assign head_B = data_q[head][1];
	assign head_PR = pr_q[head];
	assign head_ROB_index = rob_q[head];
	assign free_count = CNT_W'(OC_ENTRIES) - count;

endmodule

/* rtl/alu.sv */
// combinational integer ALU for the register-register operations
module alu import core_types_pkg::*; (
	input alu_op_t op,
	input word_t A,
	input word_t B,
	output word_t result
);

	logic [4:0] shamt;

	// shifts only look at the low bits of B
	assign shamt = B[4:0];

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = A + B;
			end
			ALU_SUB: begin
				result = A - B;
			end
			ALU_SLL: begin
				result = A << shamt;
			end
			ALU_SLT: begin
				result = {31'b0, $signed(A) < $signed(B)};
			end
			ALU_SLTU: begin
				result = {31'b0, A < B};
			end
			ALU_XOR: begin
				result = A ^ B;
			end
			ALU_SRL: begin
				result = A >> shamt;
			end
			ALU_SRA: begin
				result = word_t'($signed(A) >>> shamt);
			end
			ALU_OR: begin
				result = A | B;
			end
			ALU_AND: begin
				result = A & B;
			end
			// unused codes
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* common/core_types_pkg.sv */
// core constants, width typedefs, ALU op codes and the issue, operand-source and writeback structs
package core_types_pkg;

	// ------------------------------
	// sizes
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	localparam int PR_COUNT = 128;
	localparam int LOG_PR_COUNT = 7;
	localparam int ROB_ENTRIES = 64;
	localparam int LOG_ROB_ENTRIES = 6;
	// pipe index is always full width, so 1 to 8 pipes fit
	localparam int MAX_FF_PIPES = 8;
	localparam int LOG_MAX_FF_PIPES = 3;

	// ------------------------------
	// widths with a meaning
	typedef logic [31:0] word_t;
	typedef logic [LOG_PR_COUNT-1:0] pr_t;
	typedef logic [LOG_ROB_ENTRIES-1:0] rob_t;
	typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
	typedef logic [LOG_MAX_FF_PIPES-1:0] ff_pipe_t;
	typedef logic [3:0] alu_op_t;

	// funct3 order, top bit picks sub / sra
	localparam alu_op_t ALU_ADD = 4'b0000;
	localparam alu_op_t ALU_SLL = 4'b0001;
	localparam alu_op_t ALU_SLT = 4'b0010;
	localparam alu_op_t ALU_SLTU = 4'b0011;
	localparam alu_op_t ALU_XOR = 4'b0100;
	localparam alu_op_t ALU_SRL = 4'b0101;
	localparam alu_op_t ALU_OR = 4'b0110;
	localparam alu_op_t ALU_AND = 4'b0111;
	localparam alu_op_t ALU_SUB = 4'b1000;
	localparam alu_op_t ALU_SRA = 4'b1101;

	// ------------------------------
	// one flag set per operand
	typedef struct packed {
		logic is_reg;
		logic is_bus_forward;
		logic is_fast_forward;
		ff_pipe_t ff_pipe;
		bank_t bank;
	} operand_src_t;

	typedef struct packed {
		alu_op_t op;
		operand_src_t src_A;
		operand_src_t src_B;
		pr_t dest_PR;
		rob_t ROB_index;
	} issue_t;

	typedef struct packed {
		word_t data;
		pr_t PR;
		rob_t ROB_index;
	} wb_t;

endpackage
